// File: compile.f
+incdir+rtl
rtl/UsiBusPkg.sv
rtl/GpioPkg.sv
rtl/GpioCsr.sv
rtl/GpioPinCell.sv
rtl/GpioEventCollector.sv
rtl/GpioBlock.sv
testbench/GpioBlockTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the GPIO block testbench with Verilator.
# Exits non-zero if the build fails, if the simulation fails, or if the log
# reports failed checks.

set -u
cd "$(dirname "$0")"

TOP=GpioBlockTb
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f compile.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/simv" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Checks failed" "$LOG"; then
	echo "Simulation reported failing checks"
	exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
	echo "Simulation ended without a pass report"
	exit 1
fi
exit 0

// File: testbench/GpioBlockTb.sv
/*
 * Testbench for the GpioBlock USI slave
 * Clock, reset, bus tasks, shadow registers and output mux reference
 * Typed compare tasks, output compare process, timeout and report
 */
`timescale 1ns/1ps
`include "gpio_defs.svh"

module GpioBlockTb;

	import UsiBusPkg::*;
	import GpioPkg::*;

	// Stimulus estimate, rounded up; the limit is twice that
	localparam int lpPlannedCycles = 2000;
	localparam int lpMaxCycles     = 2 * lpPlannedCycles;
	localparam int lpResetCycles   = 16;
	localparam blockAdrs_t lpBlock      = `GPIO_BLOCK_ADRS;
	localparam blockAdrs_t lpOtherBlock = 8'h02;

	logic     iSCLK;
	logic     arstN;
	usiData_t iSUsiWd;
	usiAdrs_t iSUsiAdrs;
	usiData_t oSUsiRd;
	gpioVec_t iGpioIn;
	gpioVec_t iGpioAltMode;
	gpioVec_t oGpioR;
	gpioVec_t oGpioDir;
	logic     oGpioIrq;

	// Shadow copies of the registers and the latch model
	gpioVec_t shOut;
	gpioVec_t shDir;
	gpioVec_t shAlt;
	gpioVec_t shEdgeEn;
	gpioVec_t shLatch;

	// Error counts per kind of check
	int dataErrs;
	int vecErrs;
	int bitErrs;
	int otherErrs;
	int cycleCount;

	// Output compare process state
	logic     muxCheckOn;
	gpioVec_t muxExpPrev;
	int       muxStable;
	int       muxChecks;

	GpioBlock #(
		.pAdrsMap     (lpBlock)
	) i_dut (
		.iSCLK        (iSCLK),
		.arstN        (arstN),
		.iSUsiWd      (iSUsiWd),
		.iSUsiAdrs    (iSUsiAdrs),
		.oSUsiRd      (oSUsiRd),
		.iGpioIn      (iGpioIn),
		.iGpioAltMode (iGpioAltMode),
		.oGpioR       (oGpioR),
		.oGpioDir     (oGpioDir),
		.oGpioIrq     (oGpioIrq)
	);

	initial iSCLK = 1'b0;
	always #4 iSCLK = ~iSCLK;

	// ------------------------------------------------------------------
	// Reference, address build, compare tasks
	// ------------------------------------------------------------------
	// Alt source where selected, CSR value elsewhere
	function automatic gpioVec_t refPinOut(gpioVec_t outV, gpioVec_t altSel, gpioVec_t altIn);
		return (altSel & altIn) | (~altSel & outV);
	endfunction

	function automatic usiAdrs_t makeAdrs(blockAdrs_t blk, csrAdrs_t off, logic wr);
		usiAdrs_t a;
		a = '0;
		a[`CSR_ADRS_WIDTH-1:0] = off;
		a[`CSR_ADRS_WIDTH +: `BLOCK_ADRS_WIDTH] = blk;
		a[`USI_WRITE_BIT] = wr;
		return a;
	endfunction

	// Pin vector zero-extended to a bus word
	function automatic usiData_t padVec(gpioVec_t v);
		usiData_t d;
		d = '0;
		d[`GPIO_WIDTH-1:0] = v;
		return d;
	endfunction

	task automatic checkData(string name, usiData_t expVal, usiData_t actVal);
		if (actVal !== expVal)
		begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
			dataErrs++;
		end
	endtask

	task automatic checkVec(string name, gpioVec_t expVal, gpioVec_t actVal);
		if (actVal !== expVal)
		begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, expVal, actVal);
			vecErrs++;
		end
	endtask

	task automatic checkBit(string name, logic expVal, logic actVal);
		if (actVal !== expVal)
		begin
			$display("ERROR t=%0t %s expected %b actual %b", $time, name, expVal, actVal);
			bitErrs++;
		end
	endtask

	// ------------------------------------------------------------------
	// USI bus tasks
	// ------------------------------------------------------------------
	// One write cycle, shadows follow writes to this block
	task automatic busWrite(blockAdrs_t blk, csrAdrs_t off, usiData_t data);
		@(negedge iSCLK);
		iSUsiAdrs = makeAdrs(blk, off, 1'b1);
		iSUsiWd   = data;
		if (blk == lpBlock)
		begin
			case (off)
				`CSR_OUT_CTRL:   shOut    = data[`GPIO_WIDTH-1:0];
				`CSR_DIR:        shDir    = data[`GPIO_WIDTH-1:0];
				`CSR_ALT_MODE:   shAlt    = data[`GPIO_WIDTH-1:0];
				`CSR_EDGE_EN:    shEdgeEn = data[`GPIO_WIDTH-1:0];
				`CSR_EDGE_LATCH: shLatch  = shLatch & ~data[`GPIO_WIDTH-1:0];
				default:         ;
			endcase
		end
		@(negedge iSCLK);
		iSUsiAdrs = '0;
		iSUsiWd   = '0;
	endtask

	// Read data is valid one edge after the address
	task automatic busRead(blockAdrs_t blk, csrAdrs_t off, output usiData_t data);
		@(negedge iSCLK);
		iSUsiAdrs = makeAdrs(blk, off, 1'b0);
		@(negedge iSCLK);
		data      = oSUsiRd;
		iSUsiAdrs = '0;
	endtask

	// ------------------------------------------------------------------
	// Output compare and timeout
	// ------------------------------------------------------------------
	// Compare oGpioR once the reference inputs held for two edges
	always @(posedge iSCLK)
	begin
		gpioVec_t expNow;
		expNow = refPinOut(shOut, shAlt, iGpioAltMode);
		if (muxCheckOn && (expNow === muxExpPrev))
		begin
			if (muxStable < 2)
				muxStable++;
		end
		else
			muxStable = 0;
		if (muxStable >= 2)
		begin
			checkVec("oGpioR", expNow, oGpioR);
			muxChecks++;
		end
		muxExpPrev = expNow;
	end

	always @(posedge iSCLK)
	begin
		cycleCount++;
		if (cycleCount >= lpMaxCycles)
		begin
			$display("Timeout: the run did not finish within %0d cycles", lpMaxCycles);
			$display("Checks failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	initial
	begin
		usiData_t rd;
		gpioVec_t val;
		gpioVec_t rise;
		gpioVec_t mask;
		int pick;
		iSUsiWd      = '0;
		iSUsiAdrs    = '0;
		iGpioIn      = '0;
		iGpioAltMode = '0;
		arstN        = 1'b0;
		{shOut, shDir, shAlt, shEdgeEn, shLatch} = '0;
		{dataErrs, vecErrs, bitErrs, otherErrs} = '0;
		cycleCount = 0;
		muxCheckOn = 1'b0;
		muxExpPrev = '0;
		muxStable  = 0;
		muxChecks  = 0;
		void'($urandom(71));
		repeat (lpResetCycles) @(negedge iSCLK);
		arstN      = 1'b1;
		muxCheckOn = 1'b1;

		// Reset values
		repeat (2) @(negedge iSCLK);
		checkVec("oGpioR", '0, oGpioR);
		checkVec("oGpioDir", '0, oGpioDir);
		checkBit("oGpioIrq", 1'b0, oGpioIrq);
		busRead(lpBlock, `CSR_OUT_CTRL, rd);
		checkData("rd OUT_CTRL", '0, rd);
		busRead(lpBlock, `CSR_DIR, rd);
		checkData("rd DIR", '0, rd);
		busRead(lpBlock, `CSR_ALT_MODE, rd);
		checkData("rd ALT_MODE", '0, rd);
		busRead(lpBlock, `CSR_IN_STATUS, rd);
		checkData("rd IN_STATUS", '0, rd);
		busRead(lpBlock, `CSR_EDGE_EN, rd);
		checkData("rd EDGE_EN", '0, rd);
		busRead(lpBlock, `CSR_EDGE_LATCH, rd);
		checkData("rd EDGE_LATCH", '0, rd);

		// Register readback with random values
		repeat (8)
		begin
			busWrite(lpBlock, `CSR_OUT_CTRL, usiData_t'($urandom()));
			busWrite(lpBlock, `CSR_DIR, usiData_t'($urandom()));
			checkVec("oGpioDir", shDir, oGpioDir);
			busWrite(lpBlock, `CSR_ALT_MODE, usiData_t'($urandom()));
			busWrite(lpBlock, `CSR_EDGE_EN, usiData_t'($urandom()));
			busRead(lpBlock, `CSR_OUT_CTRL, rd);
			checkData("rd OUT_CTRL", padVec(shOut), rd);
			busRead(lpBlock, `CSR_DIR, rd);
			checkData("rd DIR", padVec(shDir), rd);
			busRead(lpBlock, `CSR_ALT_MODE, rd);
			checkData("rd ALT_MODE", padVec(shAlt), rd);
			busRead(lpBlock, `CSR_EDGE_EN, rd);
			checkData("rd EDGE_EN", padVec(shEdgeEn), rd);
		end

		// Output mux, the compare process does the checking
		repeat (200)
		begin
			pick = $urandom_range(2, 0);
			if (pick == 0)
				busWrite(lpBlock, `CSR_OUT_CTRL, usiData_t'($urandom()));
			else if (pick == 1)
				busWrite(lpBlock, `CSR_ALT_MODE, usiData_t'($urandom()));
			else
			begin
				@(negedge iSCLK);
				iGpioAltMode = gpioVec_t'($urandom());
			end
			repeat ($urandom_range(3, 0)) @(negedge iSCLK);
		end
		repeat (4) @(negedge iSCLK);

		// Input status through the synchronizer
		repeat (10)
		begin
			@(negedge iSCLK);
			val     = gpioVec_t'($urandom());
			iGpioIn = val;
			repeat (3) @(negedge iSCLK);
			busRead(lpBlock, `CSR_IN_STATUS, rd);
			checkData("rd IN_STATUS", padVec(val), rd);
		end

		// Edge capture and write-one-to-clear
		repeat (6)
		begin
			@(negedge iSCLK);
			iGpioIn = '0;
			repeat (4) @(negedge iSCLK);
			busWrite(lpBlock, `CSR_EDGE_EN, usiData_t'($urandom()));
			busWrite(lpBlock, `CSR_EDGE_LATCH, padVec('1));
			busRead(lpBlock, `CSR_EDGE_LATCH, rd);
			checkVec("edgeLatch", '0, rd[`GPIO_WIDTH-1:0]);
			// Rise on chosen pins, then let the pulse settle
			@(negedge iSCLK);
			rise    = gpioVec_t'($urandom());
			iGpioIn = rise;
			shLatch = shLatch | (rise & shEdgeEn);
			repeat (6) @(negedge iSCLK);
			busRead(lpBlock, `CSR_EDGE_LATCH, rd);
			checkVec("edgeLatch", shLatch, rd[`GPIO_WIDTH-1:0]);
			checkBit("oGpioIrq", |shLatch, oGpioIrq);
			mask = gpioVec_t'($urandom());
			busWrite(lpBlock, `CSR_EDGE_LATCH, padVec(mask));
			busRead(lpBlock, `CSR_EDGE_LATCH, rd);
			checkVec("edgeLatch", shLatch, rd[`GPIO_WIDTH-1:0]);
			repeat (2) @(negedge iSCLK);
			checkBit("oGpioIrq", |shLatch, oGpioIrq);
		end

		// Block decode, other block and unused offsets
		busWrite(lpOtherBlock, `CSR_OUT_CTRL, usiData_t'($urandom()));
		busWrite(lpOtherBlock, `CSR_DIR, usiData_t'($urandom()));
		busWrite(lpOtherBlock, `CSR_ALT_MODE, usiData_t'($urandom()));
		busWrite(lpOtherBlock, `CSR_EDGE_EN, usiData_t'($urandom()));
		busWrite(lpBlock, 8'h18, usiData_t'($urandom()));
		busRead(lpBlock, `CSR_OUT_CTRL, rd);
		checkData("rd OUT_CTRL", padVec(shOut), rd);
		busRead(lpBlock, `CSR_DIR, rd);
		checkData("rd DIR", padVec(shDir), rd);
		busRead(lpBlock, `CSR_ALT_MODE, rd);
		checkData("rd ALT_MODE", padVec(shAlt), rd);
		busRead(lpBlock, `CSR_EDGE_EN, rd);
		checkData("rd EDGE_EN", padVec(shEdgeEn), rd);
		busRead(lpOtherBlock, `CSR_OUT_CTRL, rd);
		checkData("rd other block", '0, rd);
		busRead(lpOtherBlock, `CSR_IN_STATUS, rd);
		checkData("rd other block", '0, rd);
		busRead(lpBlock, 8'h18, rd);
		checkData("rd unused offset", '0, rd);
		busRead(lpBlock, 8'h40, rd);
		checkData("rd unused offset", '0, rd);

		// Report
		repeat (2) @(negedge iSCLK);
		if (muxChecks == 0)
		begin
			$display("The output mux compare never ran, inputs were never stable");
			otherErrs++;
		end
		$display("Error counts: data %0d, vector %0d, bit %0d, other %0d",
			dataErrs, vecErrs, bitErrs, otherErrs);
		if (dataErrs + vecErrs + bitErrs + otherErrs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: rtl/GpioBlock.sv
/*
 * GpioBlock: top level of the GPIO slave on the USI bus
 * Register file, one pin cell per pin, and the edge event collector
 */
`timescale 1ns/1ps
`include "gpio_defs.svh"

module GpioBlock #(
	parameter UsiBusPkg::blockAdrs_t pAdrsMap = `GPIO_BLOCK_ADRS
)(
	// Clock and reset
	input  logic                 iSCLK,
	input  logic                 arstN,
	// USI slave side
	input  UsiBusPkg::usiData_t  iSUsiWd,
	input  UsiBusPkg::usiAdrs_t  iSUsiAdrs,
	output UsiBusPkg::usiData_t  oSUsiRd,
	// Pins
	input  GpioPkg::gpioVec_t    iGpioIn,
	input  GpioPkg::gpioVec_t    iGpioAltMode,
	output GpioPkg::gpioVec_t    oGpioR,
	output GpioPkg::gpioVec_t    oGpioDir,
	output logic                 oGpioIrq
);

	import GpioPkg::*;

	// CSR to pin side
	gpioVec_t outCtrl;
	gpioVec_t altModeSel;
	gpioVec_t edgeEn;
	gpioVec_t edgeClr;
	// Pin side back to CSR
	gpioVec_t inSync;
	gpioVec_t risePulse;
	gpioVec_t edgeLatch;

	//-------------------------------------------------------------------
	// Register file
	//-------------------------------------------------------------------
	GpioCsr #(
		.pAdrsMap   (pAdrsMap)
	) uCsr (
		.iSCLK      (iSCLK),
		.arstN      (arstN),
		.iSUsiWd    (iSUsiWd),
		.iSUsiAdrs  (iSUsiAdrs),
		.oSUsiRd    (oSUsiRd),
		.inSync     (inSync),
		.edgeLatch  (edgeLatch),
		.outCtrl    (outCtrl),
		.gpioDir    (oGpioDir),
		.altModeSel (altModeSel),
		.edgeEn     (edgeEn),
		.edgeClr    (edgeClr)
	);

	//-------------------------------------------------------------------
	// Pin cells, bit k of every vector goes to cell k
	//-------------------------------------------------------------------
	for (genvar k = 0; k < `GPIO_WIDTH; k++)
	begin : gPin
		GpioPinCell uPinCell (
			.iSCLK      (iSCLK),
			.arstN      (arstN),
			.outCtrl    (outCtrl[k]),
			.altModeSel (altModeSel[k]),
			.altIn      (iGpioAltMode[k]),
			.pinOut     (oGpioR[k]),
			.pinIn      (iGpioIn[k]),
			.inSync     (inSync[k]),
			.risePulse  (risePulse[k])
		);
	end

	//-------------------------------------------------------------------
	// Edge latch and interrupt
	//-------------------------------------------------------------------
	GpioEventCollector uEvents (
		.iSCLK      (iSCLK),
		.arstN      (arstN),
		.risePulse  (risePulse),
		.edgeEn     (edgeEn),
		.edgeClr    (edgeClr),
		.edgeLatch  (edgeLatch),
		.oGpioIrq   (oGpioIrq)
	);

endmodule

// File: rtl/GpioEventCollector.sv
/*
 * GpioEventCollector: sticky rising edge latch for all pins
 * Enable mask, write-one-to-clear, and a registered interrupt line
 */
`timescale 1ns/1ps
`include "gpio_defs.svh"

module GpioEventCollector (
	// Clock and reset
	input  logic              iSCLK,
	input  logic              arstN,
	// Edge pulses from the pin cells
	input  GpioPkg::gpioVec_t risePulse,
	// Control from the CSR
	input  GpioPkg::gpioVec_t edgeEn,
	input  GpioPkg::gpioVec_t edgeClr,
	// Latch state and interrupt
	output GpioPkg::gpioVec_t edgeLatch,
	output logic              oGpioIrq
);

	import GpioPkg::*;

	// Enabled edges this cycle
	gpioVec_t setBits;
	// Next latch value
	gpioVec_t latchNext;

	//-------------------------------------------------------------------
	// Latch update
	//-------------------------------------------------------------------
	assign setBits = risePulse & edgeEn;

	// Clear first, then set, so a new edge beats a clear on the same bit
	assign latchNext = (edgeLatch & ~edgeClr) | setBits;

	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			edgeLatch <= '0;
		else
			edgeLatch <= latchNext;
	end

	//-------------------------------------------------------------------
	// Interrupt
	//-------------------------------------------------------------------
	// Any pending bit raises the line, one cycle behind the latch
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			oGpioIrq <= 1'b0;
		else
			oGpioIrq <= |edgeLatch;
	end

	// Irq tracks the latch contents of the cycle before
	aIrqTrack : assert property (@(posedge iSCLK) disable iff (!arstN)
		oGpioIrq == $past(|edgeLatch));

endmodule

// File: rtl/GpioPinCell.sv
/*
 * GpioPinCell: one pin of the GPIO block
 * Registered output mux, two-flop input synchronizer, rising edge pulse
 */
`timescale 1ns/1ps

module GpioPinCell (
	// Clock and reset
	input  logic iSCLK,
	input  logic arstN,
	// Output side
	input  logic outCtrl,
	input  logic altModeSel,
	input  logic altIn,
	output logic pinOut,
	// Input side
	input  logic pinIn,
	output logic inSync,
	output logic risePulse
);

	// First synchronizer stage and edge history
	logic syncMeta;
	logic inHist;

	//-------------------------------------------------------------------
	// Output register
	//-------------------------------------------------------------------
	// Alt source wins when its select bit is set
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			pinOut <= 1'b0;
		else
			pinOut <= altModeSel ? altIn : outCtrl;
	end

	//-------------------------------------------------------------------
	// Input synchronizer and edge detect
	//-------------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			syncMeta  <= 1'b0;
			inSync    <= 1'b0;
			inHist    <= 1'b0;
			risePulse <= 1'b0;
		end
		else
		begin
			syncMeta  <= pinIn;
			inSync    <= syncMeta;
			// Previous synced value
			inHist    <= inSync;
			// High for one cycle on a 0 to 1 change
			risePulse <= inSync & ~inHist;
		end
	end

	// Edge pulse never lasts two cycles
	aPulseWidth : assert property (@(posedge iSCLK) disable iff (!arstN)
		risePulse |=> !risePulse);

endmodule

// File: rtl/GpioCsr.sv
/*
 * GpioCsr: USI slave decode and GPIO register file
 * Four read-write registers, read-only input status and edge latch view
 * Registered read multiplexer and one-cycle clear pulse for the latch
 */
`timescale 1ns/1ps
`include "gpio_defs.svh"

module GpioCsr #(
	parameter UsiBusPkg::blockAdrs_t pAdrsMap = `GPIO_BLOCK_ADRS
)(
	// Clock and reset
	input  logic                 iSCLK,
	input  logic                 arstN,
	// USI slave side
	input  UsiBusPkg::usiData_t  iSUsiWd,
	input  UsiBusPkg::usiAdrs_t  iSUsiAdrs,
	output UsiBusPkg::usiData_t  oSUsiRd,
	// Status from the pin side
	input  GpioPkg::gpioVec_t    inSync,
	input  GpioPkg::gpioVec_t    edgeLatch,
	// Register outputs
	output GpioPkg::gpioVec_t    outCtrl,
	output GpioPkg::gpioVec_t    gpioDir,
	output GpioPkg::gpioVec_t    altModeSel,
	output GpioPkg::gpioVec_t    edgeEn,
	output GpioPkg::gpioVec_t    edgeClr
);

	import UsiBusPkg::*;
	import GpioPkg::*;

	// Zero fill above the pin bits on read data
	localparam int lpPadWidth = `USI_BUS_WIDTH - `GPIO_WIDTH;

	//-------------------------------------------------------------------
	// Address decode
	//-------------------------------------------------------------------
	blockAdrs_t blockField;
	csrAdrs_t   csrOffset;
	logic       writeFlag;
	logic       blockHit;
	logic       csrWrite;
	logic       csrRead;
	logic       latchWrite;
	gpioVec_t   wrVec;
	gpioVec_t   rdMux;

	// Block field sits just above the offset field
	assign blockField = iSUsiAdrs[`CSR_ADRS_WIDTH +: `BLOCK_ADRS_WIDTH];
	assign csrOffset  = iSUsiAdrs[`CSR_ADRS_WIDTH-1:0];
	assign writeFlag  = iSUsiAdrs[`USI_WRITE_BIT];

	// Idle address is all zeros, block 0 never matches
	assign blockHit   = (blockField == pAdrsMap);
	assign csrWrite   = blockHit & writeFlag;
	assign csrRead    = blockHit & ~writeFlag;
	assign latchWrite = csrWrite && (csrOffset == `CSR_EDGE_LATCH);

	// Only the low pin bits of write data are stored
	assign wrVec = iSUsiWd[`GPIO_WIDTH-1:0];

	//-------------------------------------------------------------------
	// Read-write registers
	//-------------------------------------------------------------------
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
		begin
			outCtrl    <= '0;
			gpioDir    <= '0;
			altModeSel <= '0;
			edgeEn     <= '0;
		end
		else if (csrWrite)
		begin
			// Unknown offsets drop the write
			case (csrOffset)
				`CSR_OUT_CTRL: outCtrl    <= wrVec;
				`CSR_DIR:      gpioDir    <= wrVec;
				`CSR_ALT_MODE: altModeSel <= wrVec;
				`CSR_EDGE_EN:  edgeEn     <= wrVec;
				default:       ;
			endcase
		end
	end

	// W1C mask for the latch, high for one cycle only
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			edgeClr <= '0;
		else
			edgeClr <= latchWrite ? wrVec : '0;
	end

	//-------------------------------------------------------------------
	// Read path
	//-------------------------------------------------------------------
	always_comb
	begin
		case (csrOffset)
			`CSR_OUT_CTRL:   rdMux = outCtrl;
			`CSR_DIR:        rdMux = gpioDir;
			`CSR_ALT_MODE:   rdMux = altModeSel;
			`CSR_IN_STATUS:  rdMux = inSync;
			`CSR_EDGE_EN:    rdMux = edgeEn;
			`CSR_EDGE_LATCH: rdMux = edgeLatch;
			default:         rdMux = '0;
		endcase
	end

	// Zero when not read, so slaves can be ORed on the bus
	always_ff @(posedge iSCLK or negedge arstN)
	begin
		if (!arstN)
			oSUsiRd <= '0;
		else if (csrRead)
			oSUsiRd <= {{lpPadWidth{1'b0}}, rdMux};
		else
			oSUsiRd <= '0;
	end

	// Read data stays quiet unless this block was read
	aRdQuiet : assert property (@(posedge iSCLK) disable iff (!arstN)
		!csrRead |=> (oSUsiRd == '0));

	// Clear pulse only follows a latch write
	aClrPulse : assert property (@(posedge iSCLK) disable iff (!arstN)
		(edgeClr != '0) |-> $past(latchWrite));

endmodule

// File: rtl/GpioPkg.sv
/*
 * Pin side vector types for the GPIO block
 */
`include "gpio_defs.svh"

package GpioPkg;

	// One bit per pin
	// Used for out value, direction, alt select, edge enable and latch
	typedef logic [`GPIO_WIDTH-1:0] gpioVec_t;

endpackage

// File: rtl/UsiBusPkg.sv
/*
 * Bus side vector types for the USI register bus
 * Data word, full address, block field and register offset
 */
`include "gpio_defs.svh"

package UsiBusPkg;

	// Write data and read data word
	typedef logic [`USI_BUS_WIDTH-1:0] usiData_t;

	// Full bus address, write flag in the top bit
	typedef logic [`USI_BUS_WIDTH-1:0] usiAdrs_t;

	// Block select field
	typedef logic [`BLOCK_ADRS_WIDTH-1:0] blockAdrs_t;

	// Register offset inside one block
	typedef logic [`CSR_ADRS_WIDTH-1:0] csrAdrs_t;

endpackage

// File: rtl/gpio_defs.svh
/*
 * Width, address map and register offset macros for the GPIO block
 * Included by the packages and the RTL modules
 */
`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// Pin count and USI bus width
`define GPIO_WIDTH        16
`define USI_BUS_WIDTH     32

// Address fields: offset in bits 7..0, block number in bits 15..8
`define CSR_ADRS_WIDTH    8
`define BLOCK_ADRS_WIDTH  8
`define USI_WRITE_BIT     31
`define GPIO_BLOCK_ADRS   8'h01

// Register offsets
`define CSR_OUT_CTRL      8'h00
`define CSR_DIR           8'h04
`define CSR_ALT_MODE      8'h08
`define CSR_IN_STATUS     8'h0C
`define CSR_EDGE_EN       8'h10
`define CSR_EDGE_LATCH    8'h14

`endif
